// File: sim/mem_vectors.txt
# pair op(1=write 0=read) master addr data strb exp_data exp_resp(0=OKAY 2=SLVERR), all hex
# pair=1 lines come in twos, issued by both masters in the same cycle
1 1 0 00000010 11112222 f 00000000 0
1 1 1 00000020 33334444 f 00000000 0
0 0 1 00000010 00000000 0 11112222 0
0 0 0 00000020 00000000 0 33334444 0
0 1 0 00000000 a5a5a5a5 f 00000000 0
0 1 1 00000004 00000000 f 00000000 0
0 1 1 00000004 deadbeef 5 00000000 0
0 0 0 00000004 00000000 0 00ad00ef 0
0 1 0 00000010 cafef00d 8 00000000 0
0 0 1 00000010 00000000 0 ca112222 0
0 1 1 000003fc 0badc0de f 00000000 0
0 0 0 000003fc 00000000 0 0badc0de 0
0 1 0 00000400 ffffffff f 00000000 2
0 0 1 00000400 00000000 0 00000000 2
0 0 0 00000000 00000000 0 a5a5a5a5 0
1 0 0 00000000 00000000 0 a5a5a5a5 0
1 0 1 000003fc 00000000 0 0badc0de 0
1 1 0 00000100 12345678 f 00000000 0
1 1 1 00000104 87654321 f 00000000 0
1 0 1 00000100 00000000 0 12345678 0
1 0 0 00000104 00000000 0 87654321 0
0 0 1 00000800 00000000 0 00000000 2

// File: vlog.f
+incdir+include
rtl/axi_pkg.sv
rtl/mem_pkg.sv
rtl/axi_lite_if.sv
rtl/sram_array.sv
rtl/axi_sram_slave.sv
rtl/axi_rr_arbiter.sv
rtl/mem_subsys_top.sv
sim/mem_subsys_checker.sv
sim/mem_subsys_tb.sv

// File: run.sh
#!/bin/sh
# Builds the memory subsystem testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
  -f vlog.f --top-module mem_subsys_tb -o mem_subsys_sim

out=$(./obj_dir/mem_subsys_sim 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx 'PASS: all tests'; then
  exit 0
else
  exit 1
fi

// File: sim/mem_subsys_tb.sv
// Vector-driven testbench for the shared memory subsystem, the simulation top with two bus masters
`timescale 1ns/10ps

module mem_subsys_tb;
  import axi_pkg::*;

  localparam int MAX_VECS       = 64;
  localparam int CYCLES_PER_VEC = 200;

  logic clk;
  logic arst_n;

  // Index 0 is the fetch master, index 1 the data master
  addr_t awaddr  [2];
  logic  awvalid [2];
  logic  awready [2];
  data_t wdata   [2];
  strb_t wstrb   [2];
  logic  wvalid  [2];
  logic  wready  [2];
  resp_t bresp   [2];
  logic  bvalid  [2];
  logic  bready  [2];
  addr_t araddr  [2];
  logic  arvalid [2];
  logic  arready [2];
  data_t rdata   [2];
  resp_t rresp   [2];
  logic  rvalid  [2];
  logic  rready  [2];

  // Vector table
  bit    v_pair     [MAX_VECS];
  bit    v_write    [MAX_VECS];
  bit    v_mst      [MAX_VECS];
  addr_t v_addr     [MAX_VECS];
  data_t v_data     [MAX_VECS];
  strb_t v_strb     [MAX_VECS];
  data_t v_exp_data [MAX_VECS];
  resp_t v_exp_resp [MAX_VECS];
  int    n_vecs;

  int errors      = 0;
  int checks      = 0;
  int cycles      = 0;
  int cycle_limit = 0;
  int done_cycle  [2];
  // Round robin starts as if m1 was served last
  int last_served = 1;

  mem_subsys_top dut0 (
    .i_aclk       (clk),
    .i_arst_n     (arst_n),
    .i_m0_awaddr  (awaddr[0]),
    .i_m0_awprot  ('0),
    .i_m0_awvalid (awvalid[0]),
    .o_m0_awready (awready[0]),
    .i_m0_wdata   (wdata[0]),
    .i_m0_wstrb   (wstrb[0]),
    .i_m0_wvalid  (wvalid[0]),
    .o_m0_wready  (wready[0]),
    .o_m0_bresp   (bresp[0]),
    .o_m0_bvalid  (bvalid[0]),
    .i_m0_bready  (bready[0]),
    .i_m0_araddr  (araddr[0]),
    .i_m0_arprot  ('0),
    .i_m0_arvalid (arvalid[0]),
    .o_m0_arready (arready[0]),
    .o_m0_rdata   (rdata[0]),
    .o_m0_rresp   (rresp[0]),
    .o_m0_rvalid  (rvalid[0]),
    .i_m0_rready  (rready[0]),
    .i_m1_awaddr  (awaddr[1]),
    .i_m1_awprot  ('0),
    .i_m1_awvalid (awvalid[1]),
    .o_m1_awready (awready[1]),
    .i_m1_wdata   (wdata[1]),
    .i_m1_wstrb   (wstrb[1]),
    .i_m1_wvalid  (wvalid[1]),
    .o_m1_wready  (wready[1]),
    .o_m1_bresp   (bresp[1]),
    .o_m1_bvalid  (bvalid[1]),
    .i_m1_bready  (bready[1]),
    .i_m1_araddr  (araddr[1]),
    .i_m1_arprot  ('0),
    .i_m1_arvalid (arvalid[1]),
    .o_m1_arready (arready[1]),
    .o_m1_rdata   (rdata[1]),
    .o_m1_rresp   (rresp[1]),
    .o_m1_rvalid  (rvalid[1]),
    .i_m1_rready  (rready[1])
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycle_limit > 0 && cycles > cycle_limit) begin
      $display("Timeout: run did not finish within %0d cycles", cycle_limit);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  // ------------------------------
  // Helpers
  // ------------------------------
  task automatic report_mismatch(input string msg);
    errors++;
    $display("CHECK FAILED at %0t: %s", $time, msg);
  endtask

  function automatic bit load_vectors();
    int          fd;
    int          got;
    string       line;
    logic [31:0] pf, of, mf, af, df, sf, ef, rf;
    n_vecs = 0;
    fd = $fopen("sim/mem_vectors.txt", "r");
    if (fd == 0) begin
      return 1'b0;
    end
    while ($fgets(line, fd) > 0) begin
      got = $sscanf(line, "%h %h %h %h %h %h %h %h", pf, of, mf, af, df, sf, ef, rf);
      // Comment lines yield no fields
      if (got == 8 && n_vecs < MAX_VECS) begin
        v_pair[n_vecs]     = pf[0];
        v_write[n_vecs]    = of[0];
        v_mst[n_vecs]      = mf[0];
        v_addr[n_vecs]     = af;
        v_data[n_vecs]     = df;
        v_strb[n_vecs]     = sf[3:0];
        v_exp_data[n_vecs] = ef;
        v_exp_resp[n_vecs] = rf[1:0];
        n_vecs++;
      end
    end
    $fclose(fd);
    return n_vecs > 0;
  endfunction

  task automatic check_outputs_low(input string when);
    for (int m = 0; m < 2; m++) begin
      checks++;
      if ({awready[m], wready[m], bvalid[m], arready[m], rvalid[m]} != 5'b0) begin
        report_mismatch($sformatf("m%0d has a ready or valid high %s", m, when));
      end
    end
  endtask

  task automatic apply_reset();
    arst_n = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    check_outputs_low("in reset");
    arst_n = 1'b1;
    @(negedge clk);
    check_outputs_low("after reset");
  endtask

  // Waits for B or R, stalls ready a random time, then accepts
  task automatic take_response(input int m, input bit is_wr, output resp_t resp,
                               output data_t data);
    int stall;
    stall = $urandom % 4;
    while (!(is_wr ? bvalid[m] : rvalid[m])) @(negedge clk);
    resp = is_wr ? bresp[m] : rresp[m];
    data = rdata[m];
    repeat (stall) begin
      @(negedge clk);
      checks++;
      if (is_wr && (!bvalid[m] || bresp[m] != resp)) begin
        report_mismatch($sformatf("m%0d B response changed while bready low", m));
      end
      if (!is_wr && (!rvalid[m] || rresp[m] != resp || rdata[m] != data)) begin
        report_mismatch($sformatf("m%0d R response changed while rready low", m));
      end
      checks++;
      if (bvalid[1-m] || rvalid[1-m]) begin
        report_mismatch($sformatf("m%0d got a response while m%0d waits", 1 - m, m));
      end
    end
    if (is_wr) begin
      bready[m] = 1'b1;
    end else begin
      rready[m] = 1'b1;
    end
    @(negedge clk);
    bready[m] = 1'b0;
    rready[m] = 1'b0;
  endtask

  task automatic run_txn(input int i);
    int    m;
    resp_t resp;
    data_t data;
    m = v_mst[i] ? 1 : 0;
    @(negedge clk);
    if (v_write[i]) begin
      awaddr[m]  = v_addr[i];
      wdata[m]   = v_data[i];
      wstrb[m]   = v_strb[i];
      awvalid[m] = 1'b1;
      wvalid[m]  = 1'b1;
      // Ready seen here means the transfer happens on the next rising edge
      while (!awready[m]) @(negedge clk);
      checks++;
      if (!wready[m]) begin
        report_mismatch($sformatf("m%0d awready without wready", m));
      end
      @(negedge clk);
      awvalid[m] = 1'b0;
      wvalid[m]  = 1'b0;
    end else begin
      araddr[m]  = v_addr[i];
      arvalid[m] = 1'b1;
      while (!arready[m]) @(negedge clk);
      @(negedge clk);
      arvalid[m] = 1'b0;
    end
    take_response(m, v_write[i], resp, data);
    done_cycle[m] = cycles;
    checks++;
    if (resp != v_exp_resp[i]) begin
      report_mismatch($sformatf("line %0d m%0d addr %h resp %0d, expected %0d",
                                i, m, v_addr[i], resp, v_exp_resp[i]));
    end
    if (!v_write[i]) begin
      checks++;
      if (data != v_exp_data[i]) begin
        report_mismatch($sformatf("line %0d m%0d addr %h read %h, expected %h",
                                  i, m, v_addr[i], data, v_exp_data[i]));
      end
    end
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------
  task automatic run_vectors();
    int i;
    int win;
    int lose;
    i = 0;
    while (i < n_vecs) begin
      if (v_pair[i] && i + 1 < n_vecs) begin
        win  = (last_served == 1) ? 0 : 1;
        lose = 1 - win;
        fork
          run_txn(i);
          run_txn(i + 1);
        join
        checks++;
        if (done_cycle[win] >= done_cycle[lose]) begin
          report_mismatch($sformatf("lines %0d and %0d: m%0d not served first", i, i + 1, win));
        end
        last_served = lose;
        i += 2;
      end else begin
        run_txn(i);
        last_served = v_mst[i] ? 1 : 0;
        i++;
      end
    end
  endtask

  initial begin
    void'($urandom(78788));
    arst_n = 1'b0;
    for (int m = 0; m < 2; m++) begin
      awaddr[m]  = '0;
      awvalid[m] = 1'b0;
      wdata[m]   = '0;
      wstrb[m]   = '0;
      wvalid[m]  = 1'b0;
      bready[m]  = 1'b0;
      araddr[m]  = '0;
      arvalid[m] = 1'b0;
      rready[m]  = 1'b0;
      done_cycle[m] = 0;
    end
    if (!load_vectors()) begin
      $display("Vector file sim/mem_vectors.txt is missing or holds no vectors");
      $display("FAIL: see errors above");
      $finish;
    end else begin
      cycle_limit = n_vecs * CYCLES_PER_VEC;
      apply_reset();
      run_vectors();
      $display("Summary: %0d vectors, %0d checks, %0d errors", n_vecs, checks, errors);
      if (errors == 0) begin
        $display("PASS: all tests");
      end else begin
        $display("FAIL: see errors above");
      end
      $finish;
    end
  end

endmodule

// File: sim/mem_subsys_checker.sv
// Assertions on the top-level AXI4-Lite ports, attached to the memory subsystem top by bind
`timescale 1ns/10ps
`include "mem_consts.svh"

module mem_subsys_checker (
  input logic                     i_aclk,
  input logic                     i_arst_n,
  input logic [1:0]               i_awready,
  input logic [1:0]               i_wready,
  input logic [1:0]               i_arready,
  input logic [1:0]               i_bvalid,
  input logic [1:0]               i_bready,
  input logic [3:0]               i_bresp,
  input logic [1:0]               i_rvalid,
  input logic [1:0]               i_rready,
  input logic [3:0]               i_rresp,
  input logic [2*`AXI_DATA_W-1:0] i_rdata
);

  for (genvar m = 0; m < 2; m++) begin : g_master
    // Response and payload wait for ready
    a_b_hold: assert property (@(posedge i_aclk) disable iff (!i_arst_n)
      i_bvalid[m] && !i_bready[m] |=> i_bvalid[m] && $stable(i_bresp[2*m +: 2]))
      else $error("m%0d B response dropped or changed before bready", m);

    a_r_hold: assert property (@(posedge i_aclk) disable iff (!i_arst_n)
      i_rvalid[m] && !i_rready[m] |=> i_rvalid[m] && $stable(i_rresp[2*m +: 2])
        && $stable(i_rdata[`AXI_DATA_W*m +: `AXI_DATA_W]))
      else $error("m%0d R response dropped or changed before rready", m);
  end

  a_reset_quiet: assert property (@(posedge i_aclk)
    !i_arst_n |-> {i_awready, i_wready, i_arready, i_bvalid, i_rvalid} == '0)
    else $error("ready or valid high toward a master during reset");

  // Only the granted master ever sees a ready
  a_one_grant: assert property (@(posedge i_aclk) disable iff (!i_arst_n)
    !(|{i_awready[0], i_wready[0], i_arready[0]} && |{i_awready[1], i_wready[1], i_arready[1]}))
    else $error("both masters ready in the same cycle");

endmodule

bind mem_subsys_top mem_subsys_checker u_checker (
  .i_aclk    (i_aclk),
  .i_arst_n  (i_arst_n),
  .i_awready ({o_m1_awready, o_m0_awready}),
  .i_wready  ({o_m1_wready, o_m0_wready}),
  .i_arready ({o_m1_arready, o_m0_arready}),
  .i_bvalid  ({o_m1_bvalid, o_m0_bvalid}),
  .i_bready  ({i_m1_bready, i_m0_bready}),
  .i_bresp   ({o_m1_bresp, o_m0_bresp}),
  .i_rvalid  ({o_m1_rvalid, o_m0_rvalid}),
  .i_rready  ({i_m1_rready, i_m0_rready}),
  .i_rresp   ({o_m1_rresp, o_m0_rresp}),
  .i_rdata   ({o_m1_rdata, o_m0_rdata})
);

// File: rtl/mem_subsys_top.sv
// Shared memory subsystem top with plain AXI4-Lite ports for the fetch master m0 and data master m1
`timescale 1ns/10ps

module mem_subsys_top (
  input  logic           i_aclk,
  input  logic           i_arst_n,
  // Master 0 (instruction fetch)
  input  axi_pkg::addr_t i_m0_awaddr,
  input  axi_pkg::prot_t i_m0_awprot,
  input  logic           i_m0_awvalid,
  output logic           o_m0_awready,
  input  axi_pkg::data_t i_m0_wdata,
  input  axi_pkg::strb_t i_m0_wstrb,
  input  logic           i_m0_wvalid,
  output logic           o_m0_wready,
  output axi_pkg::resp_t o_m0_bresp,
  output logic           o_m0_bvalid,
  input  logic           i_m0_bready,
  input  axi_pkg::addr_t i_m0_araddr,
  input  axi_pkg::prot_t i_m0_arprot,
  input  logic           i_m0_arvalid,
  output logic           o_m0_arready,
  output axi_pkg::data_t o_m0_rdata,
  output axi_pkg::resp_t o_m0_rresp,
  output logic           o_m0_rvalid,
  input  logic           i_m0_rready,
  // Master 1 (data)
  input  axi_pkg::addr_t i_m1_awaddr,
  input  axi_pkg::prot_t i_m1_awprot,
  input  logic           i_m1_awvalid,
  output logic           o_m1_awready,
  input  axi_pkg::data_t i_m1_wdata,
  input  axi_pkg::strb_t i_m1_wstrb,
  input  logic           i_m1_wvalid,
  output logic           o_m1_wready,
  output axi_pkg::resp_t o_m1_bresp,
  output logic           o_m1_bvalid,
  input  logic           i_m1_bready,
  input  axi_pkg::addr_t i_m1_araddr,
  input  axi_pkg::prot_t i_m1_arprot,
  input  logic           i_m1_arvalid,
  output logic           o_m1_arready,
  output axi_pkg::data_t o_m1_rdata,
  output axi_pkg::resp_t o_m1_rresp,
  output logic           o_m1_rvalid,
  input  logic           i_m1_rready
);
  import axi_pkg::*;
  import mem_pkg::*;

  axi_lite_if m0_bus ();
  axi_lite_if m1_bus ();
  axi_lite_if mem_bus ();

  logic      mem_en;
  logic      mem_we;
  word_idx_t mem_idx;
  strb_t     mem_strb;
  data_t     mem_wdata;
  data_t     mem_rdata;

  // ------------------------------
  // Master 0 ports
  // ------------------------------
  assign m0_bus.awaddr  = i_m0_awaddr;
  assign m0_bus.awprot  = i_m0_awprot;
  assign m0_bus.awvalid = i_m0_awvalid;
  assign m0_bus.wdata   = i_m0_wdata;
  assign m0_bus.wstrb   = i_m0_wstrb;
  assign m0_bus.wvalid  = i_m0_wvalid;
  assign m0_bus.bready  = i_m0_bready;
  assign m0_bus.araddr  = i_m0_araddr;
  assign m0_bus.arprot  = i_m0_arprot;
  assign m0_bus.arvalid = i_m0_arvalid;
  assign m0_bus.rready  = i_m0_rready;
  assign o_m0_awready   = m0_bus.awready;
  assign o_m0_wready    = m0_bus.wready;
  assign o_m0_bresp     = m0_bus.bresp;
  assign o_m0_bvalid    = m0_bus.bvalid;
  assign o_m0_arready   = m0_bus.arready;
  assign o_m0_rdata     = m0_bus.rdata;
  assign o_m0_rresp     = m0_bus.rresp;
  assign o_m0_rvalid    = m0_bus.rvalid;

  // ------------------------------
  // Master 1 ports
  // ------------------------------
  assign m1_bus.awaddr  = i_m1_awaddr;
  assign m1_bus.awprot  = i_m1_awprot;
  assign m1_bus.awvalid = i_m1_awvalid;
  assign m1_bus.wdata   = i_m1_wdata;
  assign m1_bus.wstrb   = i_m1_wstrb;
  assign m1_bus.wvalid  = i_m1_wvalid;
  assign m1_bus.bready  = i_m1_bready;
  assign m1_bus.araddr  = i_m1_araddr;
  assign m1_bus.arprot  = i_m1_arprot;
  assign m1_bus.arvalid = i_m1_arvalid;
  assign m1_bus.rready  = i_m1_rready;
  assign o_m1_awready   = m1_bus.awready;
  assign o_m1_wready    = m1_bus.wready;
  assign o_m1_bresp     = m1_bus.bresp;
  assign o_m1_bvalid    = m1_bus.bvalid;
  assign o_m1_arready   = m1_bus.arready;
  assign o_m1_rdata     = m1_bus.rdata;
  assign o_m1_rresp     = m1_bus.rresp;
  assign o_m1_rvalid    = m1_bus.rvalid;

  axi_rr_arbiter u_arbiter (
    .i_aclk   (i_aclk),
    .i_arst_n (i_arst_n),
    .m0       (m0_bus.slave),
    .m1       (m1_bus.slave),
    .s        (mem_bus.master)
  );

  axi_sram_slave u_slave (
    .i_aclk      (i_aclk),
    .i_arst_n    (i_arst_n),
    .s           (mem_bus.slave),
    .o_mem_en    (mem_en),
    .o_mem_we    (mem_we),
    .o_mem_idx   (mem_idx),
    .o_mem_strb  (mem_strb),
    .o_mem_wdata (mem_wdata),
    .i_mem_rdata (mem_rdata)
  );

  sram_array u_sram (
    .i_aclk  (i_aclk),
    .i_en    (mem_en),
    .i_we    (mem_we),
    .i_idx   (mem_idx),
    .i_strb  (mem_strb),
    .i_wdata (mem_wdata),
    .o_rdata (mem_rdata)
  );

endmodule

// File: rtl/axi_rr_arbiter.sv
// Round-robin arbiter for two AXI4-Lite masters, grant locked until the response handshake
`timescale 1ns/10ps
`include "mem_consts.svh"

module axi_rr_arbiter (
  input  logic       i_aclk,
  input  logic       i_arst_n,
  axi_lite_if.slave  m0,
  axi_lite_if.slave  m1,
  axi_lite_if.master s
);
  import mem_pkg::*;

  arb_state_t state_q;
  // Current owner while locked, last owner while free
  logic       owner_q;
  logic       wr_req0;
  logic       wr_req1;
  logic       req0;
  logic       req1;
  logic       pick;
  logic       pick_wr;
  logic       wr_own;
  logic       rd_own;

  // ------------------------------
  // Request and pick
  // ------------------------------
  assign wr_req0 = m0.awvalid & m0.wvalid;
  assign wr_req1 = m1.awvalid & m1.wvalid;
  assign req0    = wr_req0 | m0.arvalid;
  assign req1    = wr_req1 | m1.arvalid;

  // Both asking means the one not served last wins
  assign pick    = (req0 & req1) ? ~owner_q : req1;
  assign pick_wr = pick ? wr_req1 : wr_req0;

  always_ff @(posedge i_aclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state_q <= FREE;
      owner_q <= `RR_RESET_OWNER;
    end else begin
      case (state_q)
        FREE: begin
          if (req0 | req1) begin
            state_q <= pick_wr ? WR_OWNED : RD_OWNED;
            owner_q <= pick;
          end
        end
        WR_OWNED: begin
          if (s.bvalid & s.bready) begin
            state_q <= FREE;
          end
        end
        RD_OWNED: begin
          if (s.rvalid & s.rready) begin
            state_q <= FREE;
          end
        end
        default: state_q <= FREE;
      endcase
    end
  end

  assign wr_own = (state_q == WR_OWNED);
  assign rd_own = (state_q == RD_OWNED);

  // ------------------------------
  // Forward path
  // ------------------------------
  assign s.awaddr  = owner_q ? m1.awaddr : m0.awaddr;
  assign s.awprot  = owner_q ? m1.awprot : m0.awprot;
  assign s.awvalid = wr_own & (owner_q ? m1.awvalid : m0.awvalid);
  assign s.wdata   = owner_q ? m1.wdata : m0.wdata;
  assign s.wstrb   = owner_q ? m1.wstrb : m0.wstrb;
  assign s.wvalid  = wr_own & (owner_q ? m1.wvalid : m0.wvalid);
  assign s.bready  = wr_own & (owner_q ? m1.bready : m0.bready);
  assign s.araddr  = owner_q ? m1.araddr : m0.araddr;
  assign s.arprot  = owner_q ? m1.arprot : m0.arprot;
  assign s.arvalid = rd_own & (owner_q ? m1.arvalid : m0.arvalid);
  assign s.rready  = rd_own & (owner_q ? m1.rready : m0.rready);

  // ------------------------------
  // Return path
  // ------------------------------
  // Handshakes reach only the owner
  assign m0.awready = wr_own & ~owner_q & s.awready;
  assign m0.wready  = wr_own & ~owner_q & s.wready;
  assign m0.bvalid  = wr_own & ~owner_q & s.bvalid;
  assign m0.arready = rd_own & ~owner_q & s.arready;
  assign m0.rvalid  = rd_own & ~owner_q & s.rvalid;
  assign m1.awready = wr_own & owner_q & s.awready;
  assign m1.wready  = wr_own & owner_q & s.wready;
  assign m1.bvalid  = wr_own & owner_q & s.bvalid;
  assign m1.arready = rd_own & owner_q & s.arready;
  assign m1.rvalid  = rd_own & owner_q & s.rvalid;

  // Payload is qualified by the valids above
  assign m0.bresp = s.bresp;
  assign m0.rdata = s.rdata;
  assign m0.rresp = s.rresp;
  assign m1.bresp = s.bresp;
  assign m1.rdata = s.rdata;
  assign m1.rresp = s.rresp;

endmodule

// File: rtl/axi_sram_slave.sv
// AXI4-Lite slave in front of the SRAM, decodes the range and answers with OKAY or SLVERR
`timescale 1ns/10ps
`include "mem_consts.svh"

module axi_sram_slave (
  input  logic               i_aclk,
  input  logic               i_arst_n,
  axi_lite_if.slave          s,
  output logic               o_mem_en,
  output logic               o_mem_we,
  output mem_pkg::word_idx_t o_mem_idx,
  output axi_pkg::strb_t     o_mem_strb,
  output axi_pkg::data_t     o_mem_wdata,
  input  axi_pkg::data_t     i_mem_rdata
);
  import axi_pkg::*;
  import mem_pkg::*;

  localparam addr_t MEM_BYTES = addr_t'(`MEM_WORDS * 4);

  slv_state_t state_q;
  resp_t      resp_q;
  logic       wr_take;
  logic       rd_take;
  logic       wr_hit;
  logic       rd_hit;

  // ------------------------------
  // Accept
  // ------------------------------
  // A write beats a read arriving in the same cycle
  assign wr_take = (state_q == IDLE) & s.awvalid & s.wvalid;
  assign rd_take = (state_q == IDLE) & s.arvalid & ~(s.awvalid & s.wvalid);

  assign wr_hit = s.awaddr < MEM_BYTES;
  assign rd_hit = s.araddr < MEM_BYTES;

  assign s.awready = wr_take;
  assign s.wready  = wr_take;
  assign s.arready = rd_take;

  // ------------------------------
  // SRAM port
  // ------------------------------
  // Out of range never touches the array
  assign o_mem_en    = (wr_take & wr_hit) | (rd_take & rd_hit);
  assign o_mem_we    = wr_take;
  assign o_mem_idx   = wr_take ? s.awaddr[`MEM_INDEX_W+1:2] : s.araddr[`MEM_INDEX_W+1:2];
  assign o_mem_strb  = s.wstrb;
  assign o_mem_wdata = s.wdata;

  always_ff @(posedge i_aclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state_q <= IDLE;
    end else begin
      case (state_q)
        IDLE: begin
          if (wr_take) begin
            state_q <= BRESP;
          end else if (rd_take) begin
            state_q <= RDATA;
          end
        end
        BRESP: begin
          if (s.bready) begin
            state_q <= IDLE;
          end
        end
        RDATA: begin
          if (s.rready) begin
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // One response code serves both B and R
  always_ff @(posedge i_aclk) begin
    if (wr_take) begin
      resp_q <= wr_hit ? RESP_OKAY : RESP_SLVERR;
    end else if (rd_take) begin
      resp_q <= rd_hit ? RESP_OKAY : RESP_SLVERR;
    end
  end

  // ------------------------------
  // Responses
  // ------------------------------
  assign s.bvalid = (state_q == BRESP);
  assign s.bresp  = resp_q;
  assign s.rvalid = (state_q == RDATA);
  assign s.rresp  = resp_q;
  // SRAM output is stable while RDATA waits for ready
  assign s.rdata  = (resp_q == RESP_OKAY) ? i_mem_rdata : '0;

endmodule

// File: rtl/sram_array.sv
// Single-port synchronous word SRAM with byte strobes, driven by the AXI SRAM slave
`timescale 1ns/10ps
`include "mem_consts.svh"

module sram_array (
  input  logic               i_aclk,
  input  logic               i_en,
  input  logic               i_we,
  input  mem_pkg::word_idx_t i_idx,
  input  axi_pkg::strb_t     i_strb,
  input  axi_pkg::data_t     i_wdata,
  output axi_pkg::data_t     o_rdata
);
  import axi_pkg::*;

  data_t mem [`MEM_WORDS];

  always_ff @(posedge i_aclk) begin
    if (i_en) begin
      if (i_we) begin
        // Only strobed bytes change
        for (int b = 0; b < $bits(strb_t); b++) begin
          if (i_strb[b]) begin
            mem[i_idx][b*8 +: 8] <= i_wdata[b*8 +: 8];
          end
        end
      end else begin
        // Held until the next enabled read
        o_rdata <= mem[i_idx];
      end
    end
  end

endmodule

// File: rtl/axi_lite_if.sv
// AXI4-Lite bundle of five channels, used between the top level, the arbiter and the SRAM slave
`timescale 1ns/10ps

interface axi_lite_if;
  import axi_pkg::*;

  // Write address
  addr_t awaddr;
  prot_t awprot;
  logic  awvalid;
  logic  awready;

  // Write data
  data_t wdata;
  strb_t wstrb;
  logic  wvalid;
  logic  wready;

  // Write response
  resp_t bresp;
  logic  bvalid;
  logic  bready;

  // Read address
  addr_t araddr;
  prot_t arprot;
  logic  arvalid;
  logic  arready;

  // Read data
  data_t rdata;
  resp_t rresp;
  logic  rvalid;
  logic  rready;

  modport master (
    output awaddr, awprot, awvalid,
    input  awready,
    output wdata, wstrb, wvalid,
    input  wready,
    input  bresp, bvalid,
    output bready,
    output araddr, arprot, arvalid,
    input  arready,
    input  rdata, rresp, rvalid,
    output rready
  );

  modport slave (
    input  awaddr, awprot, awvalid,
    output awready,
    input  wdata, wstrb, wvalid,
    output wready,
    output bresp, bvalid,
    input  bready,
    input  araddr, arprot, arvalid,
    output arready,
    output rdata, rresp, rvalid,
    input  rready
  );

endinterface

// File: rtl/mem_pkg.sv
// Memory-side types used by the SRAM slave, the arbiter and the SRAM array
`include "mem_consts.svh"

package mem_pkg;

  // Word index into the SRAM
  typedef logic [`MEM_INDEX_W-1:0] word_idx_t;

  // Slave handles one transaction at a time
  typedef enum logic [1:0] {
    IDLE,
    RDATA,
    BRESP
  } slv_state_t;

  // Arbiter grant, locked until the response handshake
  typedef enum logic [1:0] {
    FREE,
    RD_OWNED,
    WR_OWNED
  } arb_state_t;

endpackage

// File: rtl/axi_pkg.sv
// AXI4-Lite bus types shared by the interface, the arbiter, the slave and the top level
`include "mem_consts.svh"

package axi_pkg;

  // Byte address and data word
  typedef logic [`AXI_ADDR_W-1:0] addr_t;
  typedef logic [`AXI_DATA_W-1:0] data_t;

  // One enable per data byte
  typedef logic [`AXI_DATA_W/8-1:0] strb_t;

  // Carried on the bus only
  typedef logic [2:0] prot_t;

  typedef logic [1:0] resp_t;

  // Response codes
  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_SLVERR = 2'b10;

endpackage

// File: include/mem_consts.svh
// Fixed sizes of the shared memory subsystem, included by the packages and the RTL that need them
`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

// ------------------------------
// Bus widths
// ------------------------------
`define AXI_ADDR_W 32
`define AXI_DATA_W 32

// ------------------------------
// SRAM geometry of 1 KiB at address 0
// ------------------------------
`define MEM_WORDS   256
`define MEM_INDEX_W 8

// Last owner after reset counts as m1 so m0 is served first
`define RR_RESET_OWNER 1'b1

`endif
